/* verilog/pitch_pkg.sv */
package pitch_pkg;

	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [6:0] addr_t;
	typedef logic [6:0] lag_t;

	localparam int L_FRAME = 40;
	localparam int HIST_LEN = 60;	// also the largest legal lag
	localparam int BUF_DEPTH = HIST_LEN + L_FRAME;

	localparam acc_t MAX_32 = 32'sh7fff_ffff;
	localparam acc_t MIN_32 = 32'sh8000_0000;
	localparam sample_t MAX_16 = 16'sh7fff;

	// 1/sqrt table, entries 16..64 of the normalized input
	localparam sample_t INV_SQRT_TAB [49] = '{
		16'sd32767, 16'sd31790, 16'sd30894, 16'sd30070, 16'sd29309, 16'sd28602, 16'sd27945,
		16'sd27330, 16'sd26755, 16'sd26214, 16'sd25705, 16'sd25225, 16'sd24770, 16'sd24339,
		16'sd23930, 16'sd23541, 16'sd23170, 16'sd22817, 16'sd22479, 16'sd22155, 16'sd21845,
		16'sd21548, 16'sd21263, 16'sd20988, 16'sd20724, 16'sd20470, 16'sd20225, 16'sd19988,
		16'sd19760, 16'sd19539, 16'sd19326, 16'sd19119, 16'sd18919, 16'sd18725, 16'sd18536,
		16'sd18354, 16'sd18176, 16'sd18004, 16'sd17837, 16'sd17674, 16'sd17515, 16'sd17361,
		16'sd17211, 16'sd17064, 16'sd16921, 16'sd16782, 16'sd16646, 16'sd16514, 16'sd16384
	};

	////////////////////////////////////////////////////////////
	// saturating fractional operators

	function automatic acc_t l_mult(input sample_t a, input sample_t b);
		acc_t p;
		p = a * b;
		if (p == 32'sh4000_0000)	// -1 * -1
			return MAX_32;
		return p <<< 1;
	endfunction

	function automatic acc_t l_add(input acc_t a, input acc_t b);
		logic signed [32:0] s;
		s = a + b;
		if (s[32] != s[31])
			return s[32] ? MIN_32 : MAX_32;
		return s[31:0];
	endfunction

	function automatic acc_t l_sub(input acc_t a, input acc_t b);
		logic signed [32:0] s;
		s = a - b;
		if (s[32] != s[31])
			return s[32] ? MIN_32 : MAX_32;
		return s[31:0];
	endfunction

	function automatic acc_t l_mac(input acc_t acc, input sample_t a, input sample_t b);
		return l_add(acc, l_mult(a, b));
	endfunction

	// only -1 * -1 can overflow here
	function automatic sample_t mult(input sample_t a, input sample_t b);
		acc_t p;
		p = (a * b) >>> 15;
		if (p > 32'sd32767)
			return MAX_16;
		return p[15:0];
	endfunction

endpackage

/* verilog/speech_buffer.sv */
module speech_buffer (
	input  logic               clk,
	input  logic               reset,
	input  logic               wr_en,
	input  pitch_pkg::addr_t   wr_addr,
	input  pitch_pkg::sample_t wr_data,
	input  pitch_pkg::addr_t   rd_addr_a,
	output pitch_pkg::sample_t rd_data_a,
	input  pitch_pkg::addr_t   rd_addr_b,
	output pitch_pkg::sample_t rd_data_b,
	input  logic               busy
);
	import pitch_pkg::*;

	// history at 0..59, frame at 60..99
	sample_t mem [BUF_DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	assign rd_data_a = mem[rd_addr_a];
	assign rd_data_b = mem[rd_addr_b];

	// buffer contents must stay put for the whole sweep
	no_write_while_busy: assert property (
		@(posedge clk) disable iff (reset)
		busy |-> !wr_en
	);

	wr_addr_in_range: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |-> wr_addr < BUF_DEPTH
	);

endmodule

/* verilog/lag_correlator.sv */
module lag_correlator (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  pitch_pkg::lag_t    lag_min,
	input  pitch_pkg::lag_t    lag_max,
	output pitch_pkg::addr_t   rd_addr_a,
	input  pitch_pkg::sample_t rd_data_a,
	output pitch_pkg::addr_t   rd_addr_b,
	input  pitch_pkg::sample_t rd_data_b,
	output logic               busy,
	output logic               corr_valid,
	output pitch_pkg::acc_t    corr,
	output pitch_pkg::lag_t    corr_lag,
	output logic               sweep_done
);
	import pitch_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ACCUMULATE,
		EMIT,
		FINISH
	} state_t;

	state_t state;
	lag_t lag;
	lag_t lag_lo;
	lag_t j;	// sample index within the frame
	acc_t acc;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			lag <= '0;
			lag_lo <= '0;
			j <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						lag <= lag_max;
						lag_lo <= lag_min;
						j <= '0;
						acc <= '0;
						state <= ACCUMULATE;
					end
				end
				ACCUMULATE:
				begin
					acc <= l_mac(acc, rd_data_a, rd_data_b);
					j <= j + 1'b1;
					if (j == lag_t'(L_FRAME - 1))
						state <= EMIT;
				end
				EMIT:
				begin
					j <= '0;
					acc <= '0;
					lag <= lag - 1'b1;	// sweep runs downward
					if (lag == lag_lo)
						state <= FINISH;
					else
						state <= ACCUMULATE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// frame sample j and its delayed partner
	assign rd_addr_a = addr_t'(HIST_LEN + j);
	assign rd_addr_b = addr_t'(HIST_LEN + j - lag);

	assign busy = (state != IDLE);
	assign corr_valid = (state == EMIT);
	assign corr = acc;
	assign corr_lag = lag;
	assign sweep_done = (state == FINISH);

	lag_range_legal: assert property (
		@(posedge clk) disable iff (reset)
		(start && state == IDLE) |->
			(lag_min <= lag_max && lag_min >= 1 && lag_max <= HIST_LEN)
	);

endmodule

/* verilog/peak_picker.sv */
module peak_picker (
	input  logic            clk,
	input  logic            reset,
	input  pitch_pkg::lag_t lag_max,
	input  logic            corr_valid,
	input  pitch_pkg::acc_t corr,
	input  pitch_pkg::lag_t corr_lag,
	input  logic            sweep_done,
	output logic            peak_valid,
	output pitch_pkg::lag_t best_lag,
	output pitch_pkg::acc_t best_corr
);
	import pitch_pkg::*;

	acc_t base;
	acc_t diff;
	logic take;

	// first lag of a sweep compares against the floor
	assign base = (corr_lag == lag_max) ? MIN_32 : best_corr;
	assign diff = l_sub(corr, base);
	assign take = !diff[31];	// ties go to the later, smaller lag

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			peak_valid <= 1'b0;
			best_corr <= MIN_32;
			best_lag <= lag_max;
		end
		else
		begin
			peak_valid <= sweep_done;
			if (corr_valid && take)
			begin
				best_corr <= corr;
				best_lag <= corr_lag;
			end
		end
	end

endmodule

/* verilog/lag_energy.sv */
module lag_energy (
	input  logic               clk,
	input  logic               reset,
	input  logic               peak_valid,
	input  pitch_pkg::lag_t    best_lag,
	input  pitch_pkg::acc_t    best_corr,
	output pitch_pkg::addr_t   rd_addr,
	input  pitch_pkg::sample_t rd_data,
	output logic               energy_valid,
	output pitch_pkg::acc_t    energy,
	output pitch_pkg::lag_t    lag_out,
	output pitch_pkg::acc_t    corr_out
);
	import pitch_pkg::*;

	logic run;
	lag_t j;
	lag_t lag;
	acc_t acc;
	acc_t corr_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			run <= 1'b0;
			energy_valid <= 1'b0;
			j <= '0;
		end
		else
		begin
			energy_valid <= 1'b0;
			if (peak_valid)
			begin
				run <= 1'b1;
				j <= '0;
				acc <= '0;
				lag <= best_lag;
				corr_q <= best_corr;
			end
			else if (run)
			begin
				acc <= l_mac(acc, rd_data, rd_data);	// square of delayed sample
				j <= j + 1'b1;
				if (j == lag_t'(L_FRAME - 1))
				begin
					run <= 1'b0;
					energy_valid <= 1'b1;
				end
			end
		end
	end

	assign rd_addr = addr_t'(HIST_LEN + j - lag);
	assign energy = acc;
	assign lag_out = lag;
	assign corr_out = corr_q;

endmodule

/* verilog/inv_sqrt_unit.sv */
module inv_sqrt_unit (
	input  logic            clk,
	input  logic            reset,
	input  logic            energy_valid,
	input  pitch_pkg::acc_t energy,
	input  pitch_pkg::lag_t lag_in,
	input  pitch_pkg::acc_t corr_in,
	output logic            inv_valid,
	output pitch_pkg::acc_t inv_out,
	output pitch_pkg::lag_t lag_out,
	output pitch_pkg::acc_t corr_out
);
	import pitch_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		NORMALIZE,
		INTERP
	} state_t;

	state_t state;
	acc_t x;
	logic [4:0] nshift;

	logic [4:0] expo;
	logic [4:0] half;
	acc_t xs;
	logic [5:0] tab_idx;
	sample_t frac;
	sample_t tab_a;
	sample_t tab_b;
	acc_t y;

	////////////////////////////////////////////////////////////
	// interpolation, valid once bit 30 of x is set

	assign expo = 5'd30 - nshift;
	assign xs = expo[0] ? x : x >>> 1;	// even exponent takes one more shift
	assign half = (expo >> 1) + 5'd1;
	assign tab_idx = xs[30:25] - 6'd16;
	assign frac = {1'b0, xs[24:10]};
	assign tab_a = INV_SQRT_TAB[tab_idx];
	assign tab_b = INV_SQRT_TAB[tab_idx + 1'b1];
	assign y = l_sub({tab_a, 16'h0000}, l_mult(tab_a - tab_b, frac));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			inv_valid <= 1'b0;
			nshift <= '0;
		end
		else
		begin
			inv_valid <= 1'b0;
			case (state)
				IDLE:
				begin
					if (energy_valid)
					begin
						x <= energy;
						nshift <= '0;
						lag_out <= lag_in;
						corr_out <= corr_in;
						if (energy <= 0)
						begin
							inv_out <= 32'sh3fff_ffff;
							inv_valid <= 1'b1;
						end
						else
							state <= NORMALIZE;
					end
				end
				NORMALIZE:
				begin
					if (x[30])
						state <= INTERP;
					else
					begin
						x <= x <<< 1;
						nshift <= nshift + 1'b1;
					end
				end
				default:
				begin
					inv_out <= y >>> half;
					inv_valid <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	tab_idx_in_range: assert property (
		@(posedge clk) disable iff (reset)
		state == INTERP |-> tab_idx < 6'd48
	);

endmodule

/* verilog/cor_normalizer.sv */
module cor_normalizer (
	input  logic               clk,
	input  logic               reset,
	input  logic               inv_valid,
	input  pitch_pkg::acc_t    inv_in,
	input  pitch_pkg::lag_t    lag_in,
	input  pitch_pkg::acc_t    corr_in,
	output logic               done,
	output pitch_pkg::lag_t    p_max,
	output pitch_pkg::sample_t cor_max
);
	import pitch_pkg::*;

	sample_t max_h;
	sample_t max_l;
	sample_t ener_h;
	sample_t ener_l;
	lag_t lag_q;
	logic split_valid;
	acc_t prod;

	// low half in the split double format, 15 bits of weight
	function automatic sample_t low_half(input acc_t v);
		acc_t t;
		t = l_sub(v >>> 1, l_mult(v[31:16], 16'sd16384));
		return t[15:0];
	endfunction

	// hi*hi plus both cross terms, hi of corr first
	assign prod = l_mac(l_mac(l_mult(max_h, ener_h), mult(max_h, ener_l), 16'sd1),
		mult(max_l, ener_h), 16'sd1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			split_valid <= 1'b0;
			done <= 1'b0;
			p_max <= '0;
			cor_max <= '0;
		end
		else
		begin
			split_valid <= inv_valid;
			done <= split_valid;
			if (inv_valid)
			begin
				max_h <= corr_in[31:16];
				max_l <= low_half(corr_in);
				ener_h <= inv_in[31:16];
				ener_l <= low_half(inv_in);
				lag_q <= lag_in;
			end
			if (split_valid)
			begin
				p_max <= lag_q;
				cor_max <= prod[15:0];
			end
		end
	end

endmodule

/* verilog/pitch_search.sv */
module pitch_search (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  pitch_pkg::lag_t    lag_min,
	input  pitch_pkg::lag_t    lag_max,
	input  logic               wr_en,
	input  pitch_pkg::addr_t   wr_addr,
	input  pitch_pkg::sample_t wr_data,
	output logic               done,
	output pitch_pkg::lag_t    p_max,
	output pitch_pkg::sample_t cor_max
);
	import pitch_pkg::*;

	addr_t rd_addr_a, rd_addr_b, cor_addr_a, en_addr;
	sample_t rd_data_a, rd_data_b;
	logic busy, corr_valid, sweep_done, peak_valid, energy_valid, inv_valid;
	acc_t corr, best_corr, energy, e_corr, inv_val, i_corr;
	lag_t corr_lag, best_lag, e_lag, i_lag;

	// port a goes to the energy stage once the sweep is over
	assign rd_addr_a = busy ? cor_addr_a : en_addr;

	speech_buffer u_buf (
		.clk(clk), .reset(reset), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr_a(rd_addr_a), .rd_data_a(rd_data_a),
		.rd_addr_b(rd_addr_b), .rd_data_b(rd_data_b), .busy(busy)
	);

	lag_correlator u_corr (
		.clk(clk), .reset(reset), .start(start), .lag_min(lag_min), .lag_max(lag_max),
		.rd_addr_a(cor_addr_a), .rd_data_a(rd_data_a),
		.rd_addr_b(rd_addr_b), .rd_data_b(rd_data_b),
		.busy(busy), .corr_valid(corr_valid), .corr(corr), .corr_lag(corr_lag),
		.sweep_done(sweep_done)
	);

	peak_picker u_peak (
		.clk(clk), .reset(reset), .lag_max(lag_max), .corr_valid(corr_valid),
		.corr(corr), .corr_lag(corr_lag), .sweep_done(sweep_done),
		.peak_valid(peak_valid), .best_lag(best_lag), .best_corr(best_corr)
	);

	lag_energy u_energy (
		.clk(clk), .reset(reset), .peak_valid(peak_valid), .best_lag(best_lag),
		.best_corr(best_corr), .rd_addr(en_addr), .rd_data(rd_data_a),
		.energy_valid(energy_valid), .energy(energy), .lag_out(e_lag), .corr_out(e_corr)
	);

	inv_sqrt_unit u_isqrt (
		.clk(clk), .reset(reset), .energy_valid(energy_valid), .energy(energy),
		.lag_in(e_lag), .corr_in(e_corr), .inv_valid(inv_valid), .inv_out(inv_val),
		.lag_out(i_lag), .corr_out(i_corr)
	);

	cor_normalizer u_norm (
		.clk(clk), .reset(reset), .inv_valid(inv_valid), .inv_in(inv_val),
		.lag_in(i_lag), .corr_in(i_corr), .done(done), .p_max(p_max), .cor_max(cor_max)
	);

endmodule

/* test/pitch_ref.svh */
`ifndef PITCH_REF_SVH
`define PITCH_REF_SVH

////////////////////////////////////////////////////////////
// fractional arithmetic, worked on 64-bit integers

function automatic int sat32(input longint v);
	if (v > 64'sd2147483647)
		return 32'sh7fff_ffff;
	if (v < -64'sd2147483648)
		return 32'sh8000_0000;
	return int'(v);
endfunction

function automatic int frac_mul(input shortint a, input shortint b);
	return sat32(2 * longint'(a) * longint'(b));	// doubled product
endfunction

function automatic int sat_add(input int a, input int b);
	return sat32(longint'(a) + longint'(b));
endfunction

function automatic int sat_sub(input int a, input int b);
	return sat32(longint'(a) - longint'(b));
endfunction

function automatic int mac(input int acc, input shortint a, input shortint b);
	return sat_add(acc, frac_mul(a, b));
endfunction

function automatic shortint mul16(input shortint a, input shortint b);
	longint p;
	p = (longint'(a) * longint'(b)) >>> 15;
	if (p > 32767)
		return 16'sh7fff;
	return shortint'(p);
endfunction

////////////////////////////////////////////////////////////
// inverse square root and split double product

function automatic int inv_sqrt_ref(input int e);
	int x;
	int ex;
	int idx;
	int fr;
	shortint ta;
	shortint tb;
	int y;
	if (e <= 0)
		return 32'h3fff_ffff;
	x = e;
	ex = 30;
	while (x < 32'h4000_0000)	// until bit 30 is set
	begin
		x = x * 2;
		ex = ex - 1;
	end
	if (ex % 2 == 0)
		x = x / 2;
	ex = ex / 2 + 1;
	idx = (x >> 25) - 16;
	fr = (x >> 10) % 32768;
	ta = INV_SQRT_TAB[idx];
	tb = INV_SQRT_TAB[idx + 1];
	y = sat_sub(int'(ta) * 65536, frac_mul(ta - tb, shortint'(fr)));
	return y >>> ex;
endfunction

function automatic shortint hi_half(input int v);
	return shortint'(v >>> 16);
endfunction

function automatic shortint lo_half(input int v);
	return shortint'(sat_sub(v >>> 1, frac_mul(hi_half(v), 16'sd16384)));
endfunction

function automatic int mpy_split(input int a, input int b);
	int r;
	r = frac_mul(hi_half(a), hi_half(b));
	r = mac(r, mul16(hi_half(a), lo_half(b)), 16'sd1);
	r = mac(r, mul16(lo_half(a), hi_half(b)), 16'sd1);
	return r;
endfunction

// whole search over one buffer image, returns the best lag
function automatic int search_ref(input shortint s [BUF_DEPTH], input int lo, input int hi,
	output shortint cm);
	int c;
	int best;
	int lag;
	int e;
	int l;
	int j;
	best = 32'sh8000_0000;
	lag = hi;
	for (l = hi; l >= lo; l--)
	begin
		c = 0;
		for (j = 0; j < L_FRAME; j++)
			c = mac(c, s[HIST_LEN + j], s[HIST_LEN + j - l]);
		if (sat_sub(c, best) >= 0)	// later lag wins a tie
		begin
			best = c;
			lag = l;
		end
	end
	e = 0;
	for (j = 0; j < L_FRAME; j++)
		e = mac(e, s[HIST_LEN + j - lag], s[HIST_LEN + j - lag]);
	cm = shortint'(mpy_split(best, inv_sqrt_ref(e)));
	return lag;
endfunction

`endif

/* test/pitch_search_tb.sv */
module pitch_search_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pitch_pkg::*;
	`include "pitch_ref.svh"

	logic clk = 1'b0;
	logic reset;
	logic start;
	lag_t lag_min;
	lag_t lag_max;
	logic wr_en;
	addr_t wr_addr;
	sample_t wr_data;
	logic done;
	lag_t p_max;
	sample_t cor_max;

	shortint img [BUF_DEPTH];	// sample k sits at k + HIST_LEN
	logic [31:0] rng_state;
	string name_q [$];
	int exp_lag_q [$];
	shortint exp_cor_q [$];
	int done_count = 0;
	int cycles = 0;
	int cycle_limit = 20;
	logic done_q = 1'b0;
	lag_t held_p = '0;
	sample_t held_c = '0;

	pitch_search u_dut (
		.clk(clk), .reset(reset), .start(start), .lag_min(lag_min), .lag_max(lag_max),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.done(done), .p_max(p_max), .cor_max(cor_max)
	);

	initial
	begin
		forever #5 clk = ~clk;
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1, "stopped at the first failure");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////////////////////////
	// buffer images

	task automatic fill_random();
		int a;
		for (a = 0; a < BUF_DEPTH; a++)
		begin
			rng_state = xorshift32(rng_state);
			img[a] = shortint'(int'(rng_state[11:0]) - 2048);	// small amplitude
		end
	endtask

	task automatic fill_periodic(input int period, input shortint amp);
		int a;
		for (a = 0; a < BUF_DEPTH; a++)
			img[a] = (a % period == 0) ? amp : 16'sd0;
	endtask

	task automatic fill_const(input shortint v);
		int a;
		for (a = 0; a < BUF_DEPTH; a++)
			img[a] = v;
	endtask

	task automatic write_buffer();
		int a;
		for (a = 0; a < BUF_DEPTH; a++)
		begin
			@(posedge clk);
			wr_en <= 1'b1;
			wr_addr <= addr_t'(a);
			wr_data <= img[a];
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// nonzero restart_after sends a second start that many cycles in
	task automatic run_search(input string name, input int lo, input int hi,
		input int restart_after);
		shortint ref_cor;
		int ref_lag;
		int seen;
		ref_lag = search_ref(img, lo, hi, ref_cor);
		cycle_limit += BUF_DEPTH + (hi - lo + 1) * (L_FRAME + 1) + 2 * L_FRAME + 60;
		write_buffer();
		name_q.push_back(name);
		exp_lag_q.push_back(ref_lag);
		exp_cor_q.push_back(ref_cor);
		seen = done_count;
		@(posedge clk);
		start <= 1'b1;
		lag_min <= lag_t'(lo);
		lag_max <= lag_t'(hi);
		@(posedge clk);
		start <= 1'b0;
		if (restart_after > 0)
		begin
			repeat (restart_after) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		while (done_count == seen)
			@(posedge clk);
	endtask

	task automatic expect_lag(input string name, input int lag);
		assert (int'(p_max) == lag)
		else report_failure($sformatf("CHECK FAILED %s: p_max expected %0d, actual %0d",
			name, lag, p_max));
	endtask

	task automatic check_result();
		string name;
		int e_lag;
		shortint e_cor;
		assert (exp_lag_q.size() > 0) else report_failure("done came with no search pending");
		name = name_q.pop_front();
		e_lag = exp_lag_q.pop_front();
		e_cor = exp_cor_q.pop_front();
		assert (int'(p_max) == e_lag)
		else report_failure($sformatf("CHECK FAILED %s: p_max expected %0d, actual %0d",
			name, e_lag, p_max));
		assert (cor_max == e_cor)
		else report_failure($sformatf("CHECK FAILED %s: cor_max expected %0d, actual %0d",
			name, e_cor, cor_max));
		done_count++;
	endtask

	////////////////////////////////////////////////////////////
	// comparison and control checks at mid cycle

	always @(negedge clk)
	begin
		if (reset)
			assert (!done) else report_failure("done went high during reset");
		else
		begin
			assert (!(done && done_q))
			else report_failure("done stayed high for more than one cycle");
			if (done)
				check_result();
			else
				assert (p_max == held_p && cor_max == held_c)
				else report_failure("p_max or cor_max changed without done");
		end
		done_q = done;
		held_p = p_max;
		held_c = cor_max;
	end

	always @(negedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
			report_failure($sformatf("timeout, done never came within %0d cycles", cycle_limit));
	end

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		lag_min = 7'd1;
		lag_max = 7'd60;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rng_state = 32'd13;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		fill_random();
		run_search("random_a", 1, 60, 0);
		fill_random();
		run_search("random_b", 1, 60, 0);
		fill_periodic(23, 16'sd1000);
		run_search("periodic", 10, 40, 0);
		expect_lag("periodic", 23);
		fill_const(16'sd0);
		run_search("zeros", 5, 50, 0);
		expect_lag("zeros", 5);	// all ties
		fill_const(-16'sd32768);
		run_search("saturation", 1, 60, 0);
		fill_random();
		run_search("single_lag", 30, 30, 0);
		expect_lag("single_lag", 30);
		fill_random();
		run_search("low_range", 1, 20, 0);
		fill_random();
		run_search("high_range", 45, 60, 0);
		fill_random();
		run_search("random_c", 7, 52, 0);

		// restart while busy and idle long enough for a stray done
		fill_random();
		run_search("restart", 20, 35, 100);
		cycle_limit += 800;
		repeat (800) @(posedge clk);

		$display("all tests passed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+test
verilog/pitch_pkg.sv
verilog/speech_buffer.sv
verilog/lag_correlator.sv
verilog/peak_picker.sv
verilog/lag_energy.sv
verilog/inv_sqrt_unit.sv
verilog/cor_normalizer.sv
verilog/pitch_search.sv
test/pitch_search_tb.sv
